// ==== all.f ====
+incdir+test
hw/spmm_pkg.sv
hw/operand_store.sv
hw/result_store.sv
hw/row_sparsity.sv
hw/booth_mult.sv
hw/serial_mult.sv
hw/mac_unit.sv
hw/spmm_control.sv
hw/spmm_top.sv
test/spmm_tb.sv

// ==== hw/booth_mult.sv ====
`timescale 1ns/10ps

module booth_mult (
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    input  spmm_pkg::elem_t a,
    input  spmm_pkg::elem_t b,
    output logic            done,
    output spmm_pkg::prod_t product
);
    import spmm_pkg::*;

    // upper part of aq is W+1 bits wide so that subtracting -128 cannot overflow
    elem_t                m;
    logic [2*W:0]         aq;
    logic [2*W:0]         aq_next;
    logic [W:0]           upper;
    logic                 q_neg;
    logic [$clog2(W)-1:0] step_cnt;
    logic                 busy;

    always_comb begin
        case ({aq[0], q_neg})
            2'b01: upper = aq[2*W:W] + {m[W-1], m};
            2'b10: upper = aq[2*W:W] - {m[W-1], m};
            default: upper = aq[2*W:W];
        endcase
        // arithmetic shift right by one
        aq_next = {upper[W], upper, aq[W-1:1]};
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
            step_cnt <= '0;
        end else begin
            done <= 1'b0;
            if (start && !busy) begin
                busy <= 1'b1;
                step_cnt <= '0;
            end else if (busy) begin
                step_cnt <= step_cnt + 1'b1;
                if (step_cnt == W - 1) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            m <= a;
            aq <= {{(W+1){1'b0}}, b};
            q_neg <= 1'b0;
        end else if (busy) begin
            aq <= aq_next;
            q_neg <= aq[0];
            if (step_cnt == W - 1) begin
                product <= aq_next[2*W-1:0];
            end
        end
    end

endmodule

// ==== hw/mac_unit.sv ====
`timescale 1ns/10ps

module mac_unit (
    input  logic              clk,
    input  logic              reset,
    input  logic              mac_start,
    input  spmm_pkg::engine_t mac_engine,
    input  spmm_pkg::elem_t   op_a,
    input  spmm_pkg::elem_t   op_b,
    output logic              mac_done,
    output spmm_pkg::prod_t   mac_product
);
    import spmm_pkg::*;

    engine_t eng_r;
    logic    booth_done;
    logic    serial_done;
    prod_t   booth_product;
    prod_t   serial_product;
    logic    dsp_pend;
    logic    dsp_done;
    prod_t   dsp_prod;
    prod_t   dsp_out;

    //////////////////////////////
    // sequential engines
    //////////////////////////////

    booth_mult u_booth (
        .clk     (clk),
        .reset   (reset),
        .start   (mac_start && mac_engine == ENG_BOOTH),
        .a       (op_a),
        .b       (op_b),
        .done    (booth_done),
        .product (booth_product)
    );

    serial_mult u_serial (
        .clk     (clk),
        .reset   (reset),
        .start   (mac_start && mac_engine == ENG_SERIAL),
        .a       (op_a),
        .b       (op_b),
        .done    (serial_done),
        .product (serial_product)
    );

    //////////////////////////////
    // single-cycle product path
    //////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            eng_r <= ENG_DSP;
            dsp_pend <= 1'b0;
            dsp_done <= 1'b0;
        end else begin
            if (mac_start) begin
                eng_r <= mac_engine;
            end
            dsp_pend <= mac_start && mac_engine == ENG_DSP;
            dsp_done <= dsp_pend;
        end
    end

    // product register then output stage, two cycles in all
    always_ff @(posedge clk) begin
        if (mac_start) begin
            dsp_prod <= op_a * op_b;
        end
        if (dsp_pend) begin
            dsp_out <= dsp_prod;
        end
    end

    always_comb begin
        case (eng_r)
            ENG_BOOTH: begin
                mac_done = booth_done;
                mac_product = booth_product;
            end
            ENG_SERIAL: begin
                mac_done = serial_done;
                mac_product = serial_product;
            end
            default: begin
                mac_done = dsp_done;
                mac_product = dsp_out;
            end
        endcase
    end

endmodule

// ==== hw/operand_store.sv ====
`timescale 1ns/10ps

module operand_store (
    input  logic            clk,
    input  logic            load_en,
    input  logic            load_sel,
    input  spmm_pkg::idx_t  load_addr,
    input  spmm_pkg::elem_t load_data,
    input  spmm_pkg::idx_t  a_addr,
    input  spmm_pkg::idx_t  b_addr,
    output spmm_pkg::elem_t a_data,
    output spmm_pkg::elem_t b_data
);
    import spmm_pkg::*;

    elem_t mem_a [N*N];
    elem_t mem_b [N*N];

    // one load port, load_sel low picks A and high picks B
    always_ff @(posedge clk) begin
        if (load_en && !load_sel) begin
            mem_a[load_addr] <= load_data;
        end
        if (load_en && load_sel) begin
            mem_b[load_addr] <= load_data;
        end
    end

    // separate read ports so a pair of operands arrives together
    always_ff @(posedge clk) begin
        a_data <= mem_a[a_addr];
        b_data <= mem_b[b_addr];
    end

endmodule

// ==== hw/result_store.sv ====
`timescale 1ns/10ps

module result_store (
    input  logic            clk,
    input  logic            c_wen,
    input  spmm_pkg::idx_t  c_addr,
    input  spmm_pkg::prod_t c_data,
    input  spmm_pkg::idx_t  result_addr,
    output spmm_pkg::prod_t result_data
);
    import spmm_pkg::*;

    prod_t mem_c [N*N];

    // each element of C is written once per run by the control
    always_ff @(posedge clk) begin
        if (c_wen) begin
            mem_c[c_addr] <= c_data;
        end
    end

    // readback shows the addressed element one cycle later
    always_ff @(posedge clk) begin
        result_data <= mem_c[result_addr];
    end

endmodule

// ==== hw/row_sparsity.sv ====
`timescale 1ns/10ps

module row_sparsity (
    input  logic              clk,
    input  logic              reset,
    input  logic              row_start,
    input  logic              elem_valid,
    input  spmm_pkg::elem_t   elem_data,
    input  spmm_pkg::prec_t   precision,
    output logic              class_valid,
    output spmm_pkg::engine_t engine
);
    import spmm_pkg::*;

    logic [$clog2(N)-1:0]   elem_cnt;
    logic [$clog2(N+1)-1:0] nz_cnt;
    logic [$clog2(N+1)-1:0] nz_final;
    prec_t                  prec_r;
    density_t               density;
    engine_t                engine_next;

    // count including the element seen this cycle
    assign nz_final = nz_cnt + (elem_data != '0);

    always_comb begin
        if (int'(nz_final) * 100 <= SPARSE_PCT * N) begin
            density = DENS_SPARSE;
        end else if (int'(nz_final) * 100 >= DENSE_PCT * N) begin
            density = DENS_DENSE;
        end else begin
            density = DENS_MEDIUM;
        end

        // only the two extreme corners leave the Booth engine
        if (density == DENS_DENSE && prec_r == PREC_HIGH) begin
            engine_next = ENG_DSP;
        end else if (density == DENS_SPARSE && prec_r == PREC_LOW) begin
            engine_next = ENG_SERIAL;
        end else begin
            engine_next = ENG_BOOTH;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            elem_cnt <= '0;
            nz_cnt <= '0;
            prec_r <= PREC_LOW;
            class_valid <= 1'b0;
            engine <= ENG_BOOTH;
        end else begin
            class_valid <= 1'b0;
            if (row_start) begin
                elem_cnt <= '0;
                nz_cnt <= '0;
                prec_r <= precision;
            end else if (elem_valid) begin
                if (elem_cnt == N - 1) begin
                    class_valid <= 1'b1;
                    engine <= engine_next;
                    elem_cnt <= '0;
                    nz_cnt <= '0;
                end else begin
                    elem_cnt <= elem_cnt + 1'b1;
                    nz_cnt <= nz_final;
                end
            end
        end
    end

endmodule

// ==== hw/serial_mult.sv ====
`timescale 1ns/10ps

module serial_mult (
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    input  spmm_pkg::elem_t a,
    input  spmm_pkg::elem_t b,
    output logic            done,
    output spmm_pkg::prod_t product
);
    import spmm_pkg::*;

    prod_t                a_sh;
    prod_t                b_sh;
    prod_t                sum;
    prod_t                addend;
    prod_t                sum_next;
    logic [$clog2(W)-1:0] step_cnt;
    logic                 busy;

    always_comb begin
        addend = b_sh[0] ? a_sh : '0;
        // the top bit of b has negative weight in two's complement
        if (step_cnt == W - 1) begin
            sum_next = sum - addend;
        end else begin
            sum_next = sum + addend;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
            step_cnt <= '0;
        end else begin
            done <= 1'b0;
            if (start && !busy) begin
                busy <= 1'b1;
                step_cnt <= '0;
            end else if (busy) begin
                step_cnt <= step_cnt + 1'b1;
                if (step_cnt == W - 1) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            a_sh <= prod_t'(a);
            b_sh <= prod_t'(b);
            sum <= '0;
        end else if (busy) begin
            sum <= sum_next;
            a_sh <= a_sh << 1;
            b_sh <= b_sh >> 1;
            if (step_cnt == W - 1) begin
                product <= sum_next;
            end
        end
    end

endmodule

// ==== hw/spmm_control.sv ====
`timescale 1ns/10ps

module spmm_control (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    output logic              busy,
    output logic              done,
    output spmm_pkg::idx_t    a_addr,
    output spmm_pkg::idx_t    b_addr,
    input  spmm_pkg::elem_t   a_data,
    input  spmm_pkg::elem_t   b_data,
    output logic              row_start,
    output logic              elem_valid,
    output spmm_pkg::elem_t   elem_data,
    input  logic              class_valid,
    input  spmm_pkg::engine_t engine,
    output logic              mac_start,
    output spmm_pkg::engine_t mac_engine,
    output spmm_pkg::elem_t   op_a,
    output spmm_pkg::elem_t   op_b,
    input  logic              mac_done,
    input  spmm_pkg::prod_t   mac_product,
    output logic              c_wen,
    output spmm_pkg::idx_t    c_addr,
    output spmm_pkg::prod_t   c_data,
    output spmm_pkg::cnt_t    macs_executed,
    output spmm_pkg::cnt_t    macs_skipped
);
    import spmm_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_STREAM,
        S_CLASS,
        S_FETCH,
        S_CHECK,
        S_MAC,
        S_WRITE
    } ctrl_state_t;

    ctrl_state_t          state;
    logic [$clog2(N)-1:0] row;
    logic [$clog2(N)-1:0] col;
    logic [$clog2(N)-1:0] k;
    engine_t              row_engine;
    prod_t                acc;
    logic                 operands_nz;
    logic                 last_k;

    assign busy = (state != S_IDLE);
    assign last_k = (k == N - 1);

    // k walks the row of A while streaming and the inner dimension afterwards
    assign a_addr = idx_t'(row * N + k);
    assign b_addr = idx_t'(k * N + col);
    assign operands_nz = (a_data != '0) && (b_data != '0);

    assign row_start = (state == S_STREAM) && (k == '0);
    assign elem_data = a_data;

    assign mac_start = (state == S_CHECK) && operands_nz;
    assign mac_engine = row_engine;
    assign op_a = a_data;
    assign op_b = b_data;

    assign c_wen = (state == S_WRITE);
    assign c_addr = idx_t'(row * N + col);
    assign c_data = acc;

    //////////////////////////////
    // sequencer
    //////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= S_IDLE;
            row <= '0;
            col <= '0;
            k <= '0;
            row_engine <= ENG_BOOTH;
            acc <= '0;
            elem_valid <= 1'b0;
            done <= 1'b0;
            macs_executed <= '0;
            macs_skipped <= '0;
        end else begin
            // read data trails the address by one cycle
            elem_valid <= (state == S_STREAM);
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        row <= '0;
                        col <= '0;
                        k <= '0;
                        acc <= '0;
                        macs_executed <= '0;
                        macs_skipped <= '0;
                        state <= S_STREAM;
                    end
                end
                S_STREAM: begin
                    k <= last_k ? '0 : k + 1'b1;
                    if (last_k) begin
                        state <= S_CLASS;
                    end
                end
                S_CLASS: begin
                    if (class_valid) begin
                        row_engine <= engine;
                        state <= S_FETCH;
                    end
                end
                S_FETCH: state <= S_CHECK;
                S_CHECK: begin
                    if (operands_nz) begin
                        macs_executed <= macs_executed + 1'b1;
                        state <= S_MAC;
                    end else begin
                        macs_skipped <= macs_skipped + 1'b1;
                        k <= last_k ? '0 : k + 1'b1;
                        state <= last_k ? S_WRITE : S_FETCH;
                    end
                end
                S_MAC: begin
                    if (mac_done) begin
                        acc <= acc + mac_product;
                        k <= last_k ? '0 : k + 1'b1;
                        state <= last_k ? S_WRITE : S_FETCH;
                    end
                end
                S_WRITE: begin
                    acc <= '0;
                    if (col == N - 1) begin
                        col <= '0;
                        if (row == N - 1) begin
                            done <= 1'b1;
                            state <= S_IDLE;
                        end else begin
                            row <= row + 1'b1;
                            state <= S_STREAM;
                        end
                    end else begin
                        col <= col + 1'b1;
                        state <= S_FETCH;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// ==== hw/spmm_pkg.sv ====
package spmm_pkg;

    //////////////////////////////
    // sizes and thresholds
    //////////////////////////////

    localparam int N = 4;
    localparam int W = 8;

    // row density limits in percent of N
    localparam int SPARSE_PCT = 30;
    localparam int DENSE_PCT = 70;

    //////////////////////////////
    // data types
    //////////////////////////////

    typedef logic signed [W-1:0] elem_t;

    // products and dot products wrap modulo 2**(2*W)
    typedef logic signed [2*W-1:0] prod_t;

    // flat element address, row * N + column
    typedef logic [$clog2(N*N)-1:0] idx_t;

    typedef logic [7:0] cnt_t;

    typedef enum logic [1:0] {
        PREC_LOW,
        PREC_MID,
        PREC_HIGH
    } prec_t;

    typedef enum logic [1:0] {
        ENG_DSP,
        ENG_BOOTH,
        ENG_SERIAL
    } engine_t;

    typedef enum logic [1:0] {
        DENS_SPARSE,
        DENS_MEDIUM,
        DENS_DENSE
    } density_t;

endpackage

// ==== hw/spmm_top.sv ====
`timescale 1ns/10ps

module spmm_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              load_en,
    input  logic              load_sel,
    input  spmm_pkg::idx_t    load_addr,
    input  spmm_pkg::elem_t   load_data,
    input  spmm_pkg::prec_t   precision,
    input  logic              start,
    output logic              busy,
    output logic              done,
    output logic              sel_valid,
    output spmm_pkg::engine_t sel_engine,
    output spmm_pkg::cnt_t    macs_executed,
    output spmm_pkg::cnt_t    macs_skipped,
    input  spmm_pkg::idx_t    result_addr,
    output spmm_pkg::prod_t   result_data
);
    import spmm_pkg::*;

    idx_t    a_addr;
    idx_t    b_addr;
    elem_t   a_data;
    elem_t   b_data;
    logic    row_start;
    logic    elem_valid;
    elem_t   elem_data;
    logic    mac_start;
    engine_t mac_engine;
    elem_t   op_a;
    elem_t   op_b;
    logic    mac_done;
    prod_t   mac_product;
    logic    c_wen;
    idx_t    c_addr;
    prod_t   c_data;

    operand_store u_operands (
        .clk       (clk),
        .load_en   (load_en),
        .load_sel  (load_sel),
        .load_addr (load_addr),
        .load_data (load_data),
        .a_addr    (a_addr),
        .b_addr    (b_addr),
        .a_data    (a_data),
        .b_data    (b_data)
    );

    // the classifier strobe is also the row report seen outside
    row_sparsity u_classify (
        .clk         (clk),
        .reset       (reset),
        .row_start   (row_start),
        .elem_valid  (elem_valid),
        .elem_data   (elem_data),
        .precision   (precision),
        .class_valid (sel_valid),
        .engine      (sel_engine)
    );

    mac_unit u_mac (
        .clk         (clk),
        .reset       (reset),
        .mac_start   (mac_start),
        .mac_engine  (mac_engine),
        .op_a        (op_a),
        .op_b        (op_b),
        .mac_done    (mac_done),
        .mac_product (mac_product)
    );

    spmm_control u_control (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .busy          (busy),
        .done          (done),
        .a_addr        (a_addr),
        .b_addr        (b_addr),
        .a_data        (a_data),
        .b_data        (b_data),
        .row_start     (row_start),
        .elem_valid    (elem_valid),
        .elem_data     (elem_data),
        .class_valid   (sel_valid),
        .engine        (sel_engine),
        .mac_start     (mac_start),
        .mac_engine    (mac_engine),
        .op_a          (op_a),
        .op_b          (op_b),
        .mac_done      (mac_done),
        .mac_product   (mac_product),
        .c_wen         (c_wen),
        .c_addr        (c_addr),
        .c_data        (c_data),
        .macs_executed (macs_executed),
        .macs_skipped  (macs_skipped)
    );

    result_store u_results (
        .clk         (clk),
        .c_wen       (c_wen),
        .c_addr      (c_addr),
        .c_data      (c_data),
        .result_addr (result_addr),
        .result_data (result_data)
    );

endmodule

// ==== test/spmm_ref.svh ====
`ifndef SPMM_REF_SVH
`define SPMM_REF_SVH

// model copies of A and B kept in step with every load
elem_t ref_a [N*N];
elem_t ref_b [N*N];

// one element of C as a plain integer dot product wrapped to 2W bits
function automatic prod_t dot_product(input int i, input int j);
    int sum;
    sum = 0;
    for (int kk = 0; kk < N; kk++) begin
        sum += int'(ref_a[i*N+kk]) * int'(ref_b[kk*N+j]);
    end
    return prod_t'(sum);
endfunction

function automatic engine_t choose_engine(input int i, input prec_t prec);
    int       nz;
    density_t dens;
    nz = 0;
    for (int kk = 0; kk < N; kk++) begin
        if (ref_a[i*N+kk] != 0) begin
            nz++;
        end
    end
    if (nz * 100 <= SPARSE_PCT * N) begin
        dens = DENS_SPARSE;
    end else if (nz * 100 >= DENSE_PCT * N) begin
        dens = DENS_DENSE;
    end else begin
        dens = DENS_MEDIUM;
    end
    if (dens == DENS_DENSE && prec == PREC_HIGH) begin
        return ENG_DSP;
    end
    if (dens == DENS_SPARSE && prec == PREC_LOW) begin
        return ENG_SERIAL;
    end
    return ENG_BOOTH;
endfunction

// operand pairs of the whole product counted by whether both are nonzero
function automatic int count_pairs(input bit both_nz);
    int cnt;
    bit nz;
    cnt = 0;
    for (int i = 0; i < N; i++) begin
        for (int j = 0; j < N; j++) begin
            for (int kk = 0; kk < N; kk++) begin
                nz = (ref_a[i*N+kk] != 0) && (ref_b[kk*N+j] != 0);
                if (nz == both_nz) begin
                    cnt++;
                end
            end
        end
    end
    return cnt;
endfunction

`endif

// ==== test/spmm_tb.sv ====
`timescale 1ns/10ps

module spmm_tb;
    import spmm_pkg::*;

    `include "spmm_ref.svh"

    // fetch, check and the slowest engine for every one of the N*N*N pairs
    localparam int MAC_CYCLES = 12;
    localparam int RUN_CYCLES = N*N*N*MAC_CYCLES + 2*N*N + 2 + N*N + 2 + 40;
    localparam int NUM_RUNS = 6;
    localparam int CYCLE_LIMIT = (NUM_RUNS * RUN_CYCLES * 7) / 6;

    logic    clk;
    logic    reset;
    logic    load_en;
    logic    load_sel;
    idx_t    load_addr;
    elem_t   load_data;
    prec_t   precision;
    logic    start;
    logic    busy;
    logic    done;
    logic    sel_valid;
    engine_t sel_engine;
    cnt_t    macs_executed;
    cnt_t    macs_skipped;
    idx_t    result_addr;
    prod_t   result_data;

    integer  seed;
    int      mismatches = 0;
    int      failures = 0;
    int      runs_checked = 0;
    int      row_seen = 0;
    int      cycles = 0;
    prec_t   run_prec = PREC_LOW;

    spmm_top UUT (
        .clk           (clk),
        .reset         (reset),
        .load_en       (load_en),
        .load_sel      (load_sel),
        .load_addr     (load_addr),
        .load_data     (load_data),
        .precision     (precision),
        .start         (start),
        .busy          (busy),
        .done          (done),
        .sel_valid     (sel_valid),
        .sel_engine    (sel_engine),
        .macs_executed (macs_executed),
        .macs_skipped  (macs_skipped),
        .result_addr   (result_addr),
        .result_data   (result_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic report_mismatch(input string what, input int expected, input int actual);
        $display("Mismatch at %0t: %s expected %0d, got %0d", $time, what, expected, actual);
        mismatches++;
    endtask

    task automatic finish_run();
        $display("Error counts: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    function automatic elem_t rand_nonzero();
        elem_t v;
        v = elem_t'($random(seed));
        if (v == 0) begin
            v = 8'sd1;
        end
        return v;
    endfunction

    task automatic fill_b(input bit with_zeros);
        for (int idx = 0; idx < N*N; idx++) begin
            if (with_zeros && ($random(seed) & 3) == 0) begin
                ref_b[idx] = '0;
            end else begin
                ref_b[idx] = rand_nonzero();
            end
        end
    endtask

    // row i gets (i + shift) mod (N + 1) nonzero elements
    task automatic build_sparse_a(input int shift);
        int nz;
        for (int i = 0; i < N; i++) begin
            nz = (i + shift) % (N + 1);
            for (int j = 0; j < N; j++) begin
                ref_a[i*N+j] = ((j + i) % N < nz) ? rand_nonzero() : elem_t'(0);
            end
        end
    endtask

    task automatic load_matrix(input bit sel);
        for (int idx = 0; idx < N*N; idx++) begin
            @(posedge clk);
            load_en <= 1'b1;
            load_sel <= sel;
            load_addr <= idx_t'(idx);
            load_data <= sel ? ref_b[idx] : ref_a[idx];
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic run_matrix(input prec_t prec);
        int target;
        int waited;
        target = runs_checked + 1;
        @(posedge clk);
        run_prec = prec;
        precision <= prec;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        if (busy !== 1'b1) begin
            $display("busy did not rise after start at %0t", $time);
            failures++;
        end
        waited = 0;
        while (runs_checked < target && waited < RUN_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        if (runs_checked < target) begin
            $display("No done within %0d cycles of start at %0t", RUN_CYCLES, $time);
            failures++;
        end
    endtask

    // address t goes out at one edge and its data is sampled two edges later
    task automatic read_back_c();
        prod_t expected;
        for (int t = 0; t < N*N + 2; t++) begin
            @(posedge clk);
            if (t >= 2) begin
                expected = dot_product((t - 2) / N, (t - 2) % N);
                if (result_data !== expected) begin
                    report_mismatch($sformatf("C[%0d]", t - 2), int'(expected),
                        int'(result_data));
                end
            end
            if (t < N*N) begin
                result_addr <= idx_t'(t);
            end
        end
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    initial begin : stimulus
        seed = 22;
        reset = 1'b1;
        load_en = 1'b0;
        load_sel = 1'b0;
        load_addr = '0;
        load_data = '0;
        precision = PREC_LOW;
        start = 1'b0;
        result_addr = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);
        if (busy !== 1'b0) report_mismatch("busy after reset", 0, busy);
        if (done !== 1'b0) report_mismatch("done after reset", 0, done);
        if (sel_valid !== 1'b0) report_mismatch("sel_valid after reset", 0, sel_valid);
        if (macs_executed !== '0) report_mismatch("macs_executed after reset", 0, macs_executed);
        if (macs_skipped !== '0) report_mismatch("macs_skipped after reset", 0, macs_skipped);

        // dense nonzero operands with signs mixed
        for (int idx = 0; idx < N*N; idx++) begin
            ref_a[idx] = rand_nonzero();
        end
        fill_b(1'b0);
        load_matrix(1'b0);
        load_matrix(1'b1);
        run_matrix(PREC_HIGH);

        // rows with 0 to 4 nonzero elements and one precision per run
        fill_b(1'b1);
        load_matrix(1'b1);
        build_sparse_a(0);
        load_matrix(1'b0);
        run_matrix(PREC_LOW);
        build_sparse_a(1);
        load_matrix(1'b0);
        run_matrix(PREC_MID);
        build_sparse_a(2);
        load_matrix(1'b0);
        run_matrix(PREC_HIGH);

        // new B only while A stays from the previous run
        fill_b(1'b0);
        load_matrix(1'b1);
        run_matrix(PREC_LOW);

        // -128 everywhere but odd rows lose one element so their sums wrap negative
        for (int idx = 0; idx < N*N; idx++) begin
            ref_a[idx] = ((idx / N) % 2 == 1 && idx % N == idx / N) ?
                elem_t'(0) : elem_t'(-128);
            ref_b[idx] = elem_t'(-128);
        end
        load_matrix(1'b0);
        load_matrix(1'b1);
        run_matrix(PREC_MID);

        finish_run();
    end

    //////////////////////////////
    // compare
    //////////////////////////////

    initial begin : compare
        forever begin
            @(posedge clk);
            if (sel_valid === 1'b1 && row_seen >= N) begin
                $display("Extra row report at %0t after all %0d rows", $time, N);
                failures++;
            end else if (sel_valid === 1'b1) begin
                if (sel_engine !== choose_engine(row_seen, run_prec)) begin
                    report_mismatch($sformatf("engine of row %0d", row_seen),
                        int'(choose_engine(row_seen, run_prec)), int'(sel_engine));
                end
                row_seen++;
            end
            if (done === 1'b1) begin
                if (busy !== 1'b0) report_mismatch("busy with done", 0, busy);
                if (row_seen != N) begin
                    $display("Only %0d of %0d row reports before done at %0t",
                        row_seen, N, $time);
                    failures++;
                end
                if (macs_executed !== cnt_t'(count_pairs(1'b1))) begin
                    report_mismatch("macs_executed", count_pairs(1'b1), int'(macs_executed));
                end
                if (macs_skipped !== cnt_t'(count_pairs(1'b0))) begin
                    report_mismatch("macs_skipped", count_pairs(1'b0), int'(macs_skipped));
                end
                if (int'(macs_executed) + int'(macs_skipped) != N*N*N) begin
                    report_mismatch("sum of MAC counters", N*N*N,
                        int'(macs_executed) + int'(macs_skipped));
                end
                read_back_c();
                row_seen = 0;
                runs_checked++;
            end
        end
    end

    initial begin : watchdog
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the tests did not complete within %0d cycles", CYCLE_LIMIT);
        failures++;
        finish_run();
    end

endmodule
